//--- hdl/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

    // major opcodes, inst[31:26]
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_JAL   = 6'h03,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_SLTI  = 6'h0a,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_LUI   = 6'h0f,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_t;

    // r-type function field, inst[5:0]
    typedef enum logic [5:0] {
        F_SLL  = 6'h00,
        F_SRL  = 6'h02,
        F_JR   = 6'h08,
        F_ADD  = 6'h20,
        F_SUB  = 6'h22,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_SLT  = 6'h2a,
        F_SLTU = 6'h2b
    } funct_t;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_SLT  = 4'd4,
        ALU_SLTU = 4'd5,
        ALU_SLL  = 4'd6,
        ALU_SRL  = 4'd7,
        ALU_LUI  = 4'd8  // immediate into the upper half
    } alu_op_t;

    typedef struct packed {
        logic    reg_dest;       // write register is rd, not rt
        logic    reg_write;
        logic    alu_src;        // operand b is the immediate
        alu_op_t alu_op;
        logic    mem_read;
        logic    mem_write;
        logic    mem_to_reg;
        logic    link;           // jal, pc+4 into r31
        logic    branch_eq;
        logic    branch_ne;
        logic    jump;
        logic    jump_register;
        logic    shamt_src;      // operand a is the shift amount
        logic    imm_unsigned;   // zero-extend the immediate
        logic    halt_illegal;   // unknown encoding, runs as a no-op
    } ctrl_t;

endpackage

`default_nettype wire

//--- hdl/mips_bus_pkg.sv
`default_nettype none

package mips_bus_pkg;

    // wishbone classic master request
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [31:0] dat;
        logic [3:0]  sel;
    } wb_req_t;

    // slave response
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

//--- hdl/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  logic [31:0]           a,
    input  logic [31:0]           b,
    input  mips_isa_pkg::alu_op_t op,
    output logic [31:0]           result,
    output logic                  zero,
    output logic                  negative
);

    logic [4:0] shamt;

    assign shamt = a[4:0];  // shift amount rides on operand a

    always_comb begin
        case (op)
            mips_isa_pkg::ALU_ADD:  result = a + b;
            mips_isa_pkg::ALU_SUB:  result = a - b;
            mips_isa_pkg::ALU_AND:  result = a & b;
            mips_isa_pkg::ALU_OR:   result = a | b;
            mips_isa_pkg::ALU_SLT: begin
                result = {31'b0, $signed(a) < $signed(b)};
            end
            mips_isa_pkg::ALU_SLTU: begin
                result = {31'b0, a < b};
            end
            mips_isa_pkg::ALU_SLL:  result = b << shamt;
            mips_isa_pkg::ALU_SRL:  result = b >> shamt;   // logical, zero fill
            mips_isa_pkg::ALU_LUI:  result = {b[15:0], 16'h0000};
            default:                result = '0;
        endcase
    end

    assign zero     = (result == 32'd0);
    assign negative = result[31];

endmodule

`default_nettype wire

//--- hdl/regfile.sv
`timescale 1ns/10ps
`default_nettype none

module regfile (
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  rs_num,
    input  logic [4:0]  rt_num,
    input  logic [4:0]  rd_num,
    input  logic [31:0] rd_data,
    input  logic        rd_we,
    output logic [31:0] rs_data,
    output logic [31:0] rt_data
);

    logic [31:0] regs [0:31];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (rd_we && rd_num != 5'd0) begin
            regs[rd_num] <= rd_data;  // r0 never written
        end
    end

    // r0 reads as zero regardless
    assign rs_data = (rs_num == 5'd0) ? 32'd0 : regs[rs_num];
    assign rt_data = (rt_num == 5'd0) ? 32'd0 : regs[rt_num];

endmodule

`default_nettype wire

//--- hdl/wb_data_port.sv
`timescale 1ns/10ps
`default_nettype none

module wb_data_port (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  mem_read,
    input  logic                  mem_write,
    input  logic                  halted,
    input  logic [31:0]           addr,
    input  logic [31:0]           wdata,
    output mips_bus_pkg::wb_req_t wb_req,
    input  mips_bus_pkg::wb_rsp_t wb_rsp,
    output logic                  stall,
    output logic [31:0]           rdata
);

    typedef enum logic [1:0] {IDLE, ACTIVE, DONE} state_t;

    state_t      state;
    logic        we_q;
    logic [31:0] adr_q;
    logic [31:0] dat_q;
    logic        mem_req;
    logic        start;
    logic        ack_seen;

    assign mem_req  = mem_read | mem_write;
    assign start    = (state == IDLE) && mem_req && !halted;
    assign ack_seen = (state == ACTIVE) && wb_rsp.ack;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            we_q  <= 1'b0;
        end else begin
            case (state)
                IDLE: if (start) begin
                    state <= ACTIVE;
                    we_q  <= mem_write;
                end
                ACTIVE: if (wb_rsp.ack) begin
                    state <= DONE;  // cyc and stb drop here
                    we_q  <= 1'b0;
                end
                default: state <= IDLE;  // gap cycle between bus cycles
            endcase
        end
    end

    // address and store data held for the whole cycle
    always_ff @(posedge clk) begin
        if (start) begin
            adr_q <= addr;
            dat_q <= wdata;
        end
    end

    always_comb begin
        wb_req.cyc = (state == ACTIVE);
        wb_req.stb = (state == ACTIVE);
        wb_req.we  = we_q;
        wb_req.adr = adr_q;
        wb_req.dat = dat_q;
        wb_req.sel = 4'hf;  // word accesses only
    end

    assign stall = mem_req && !ack_seen;
    assign rdata = wb_rsp.dat;

endmodule

`default_nettype wire

//--- hdl/control_unit.sv
`timescale 1ns/10ps
`default_nettype none

module control_unit (
    input  mips_isa_pkg::opcode_t opcode,
    input  mips_isa_pkg::funct_t  funct,
    output mips_isa_pkg::ctrl_t   ctrl
);

    always_comb begin
        ctrl = '0;  // alu_op defaults to add
        case (opcode)
            mips_isa_pkg::OP_RTYPE: begin
                ctrl.reg_dest  = 1'b1;
                ctrl.reg_write = 1'b1;
                case (funct)
                    mips_isa_pkg::F_ADD:  ctrl.alu_op = mips_isa_pkg::ALU_ADD;
                    mips_isa_pkg::F_SUB:  ctrl.alu_op = mips_isa_pkg::ALU_SUB;
                    mips_isa_pkg::F_AND:  ctrl.alu_op = mips_isa_pkg::ALU_AND;
                    mips_isa_pkg::F_OR:   ctrl.alu_op = mips_isa_pkg::ALU_OR;
                    mips_isa_pkg::F_SLT:  ctrl.alu_op = mips_isa_pkg::ALU_SLT;
                    mips_isa_pkg::F_SLTU: ctrl.alu_op = mips_isa_pkg::ALU_SLTU;
                    mips_isa_pkg::F_SLL: begin
                        ctrl.alu_op    = mips_isa_pkg::ALU_SLL;
                        ctrl.shamt_src = 1'b1;
                    end
                    mips_isa_pkg::F_SRL: begin
                        ctrl.alu_op    = mips_isa_pkg::ALU_SRL;
                        ctrl.shamt_src = 1'b1;
                    end
                    mips_isa_pkg::F_JR: begin
                        ctrl.reg_write     = 1'b0;
                        ctrl.jump_register = 1'b1;
                    end
                    default: begin
                        ctrl              = '0;
                        ctrl.halt_illegal = 1'b1;
                    end
                endcase
            end
            mips_isa_pkg::OP_ADDI: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            mips_isa_pkg::OP_ANDI, mips_isa_pkg::OP_ORI: begin
                ctrl.reg_write    = 1'b1;
                ctrl.alu_src      = 1'b1;
                ctrl.imm_unsigned = 1'b1;
                ctrl.alu_op       = (opcode == mips_isa_pkg::OP_ANDI) ?
                                    mips_isa_pkg::ALU_AND : mips_isa_pkg::ALU_OR;
            end
            mips_isa_pkg::OP_SLTI: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = mips_isa_pkg::ALU_SLT;
            end
            mips_isa_pkg::OP_LUI: begin
                ctrl.reg_write    = 1'b1;
                ctrl.alu_src      = 1'b1;
                ctrl.imm_unsigned = 1'b1;
                ctrl.alu_op       = mips_isa_pkg::ALU_LUI;
            end
            mips_isa_pkg::OP_LW: begin
                ctrl.reg_write  = 1'b1;
                ctrl.alu_src    = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
            end
            mips_isa_pkg::OP_SW: begin
                ctrl.alu_src   = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            mips_isa_pkg::OP_BEQ: begin
                ctrl.alu_op    = mips_isa_pkg::ALU_SUB;  // zero flag means equal
                ctrl.branch_eq = 1'b1;
            end
            mips_isa_pkg::OP_BNE: begin
                ctrl.alu_op    = mips_isa_pkg::ALU_SUB;
                ctrl.branch_ne = 1'b1;
            end
            mips_isa_pkg::OP_J:   ctrl.jump = 1'b1;
            mips_isa_pkg::OP_JAL: begin
                ctrl.jump      = 1'b1;
                ctrl.link      = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            default: ctrl.halt_illegal = 1'b1;  // no writes, pc+4
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/data_path.sv
`timescale 1ns/10ps
`default_nettype none

module data_path #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  halted,
    input  logic [31:0]           inst,
    input  mips_isa_pkg::ctrl_t   ctrl,
    output logic [31:0]           inst_addr,
    output mips_bus_pkg::wb_req_t wb_req,
    input  mips_bus_pkg::wb_rsp_t wb_rsp
);

    logic [31:0] pc;
    logic [31:0] pc_plus4;
    logic [31:0] imm_sext;
    logic [31:0] imm_zext;
    logic [31:0] imm;
    logic [31:0] branch_target;
    logic [31:0] jump_target;
    logic [31:0] next_pc;
    logic        branch_taken;

    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic [31:0] alu_a;
    logic [31:0] alu_b;
    logic [31:0] alu_result;
    logic        alu_zero;

    logic [4:0]  rd_num;
    logic [31:0] rd_data;
    logic        rd_we;
    logic [31:0] load_data;
    logic        stall;
    logic        retire;   // instruction completes at this edge

    assign inst_addr = pc;
    assign pc_plus4  = pc + 32'd4;

    // immediate extension
    assign imm_sext = {{16{inst[15]}}, inst[15:0]};
    assign imm_zext = {16'h0000, inst[15:0]};
    assign imm      = ctrl.imm_unsigned ? imm_zext : imm_sext;

    assign branch_target = pc_plus4 + {imm_sext[29:0], 2'b00};
    assign jump_target   = {pc_plus4[31:28], inst[25:0], 2'b00};

    assign branch_taken = (ctrl.branch_eq && alu_zero) || (ctrl.branch_ne && !alu_zero);

    always_comb begin
        if (ctrl.jump_register)
            next_pc = rs_data;
        else if (ctrl.jump)
            next_pc = jump_target;
        else if (branch_taken)
            next_pc = branch_target;
        else
            next_pc = pc_plus4;
    end

    assign retire = !stall && !halted;

    always_ff @(posedge clk) begin
        if (rst)
            pc <= RESET_PC;
        else if (retire)
            pc <= next_pc;
    end

    // operand muxes
    assign alu_a = ctrl.shamt_src ? {27'd0, inst[10:6]} : rs_data;
    assign alu_b = ctrl.alu_src ? imm : rt_data;

    alu u_alu (
        .a        (alu_a),
        .b        (alu_b),
        .op       (ctrl.alu_op),
        .result   (alu_result),
        .zero     (alu_zero),
        .negative ()
    );

    // write register: r31 for jal, else rd or rt
    always_comb begin
        if (ctrl.link)
            rd_num = 5'd31;
        else if (ctrl.reg_dest)
            rd_num = inst[15:11];
        else
            rd_num = inst[20:16];
    end

    always_comb begin
        if (ctrl.link)
            rd_data = pc_plus4;
        else if (ctrl.mem_to_reg)
            rd_data = load_data;
        else
            rd_data = alu_result;
    end

    assign rd_we = ctrl.reg_write && !ctrl.halt_illegal && retire;

    regfile u_regfile (
        .clk     (clk),
        .rst     (rst),
        .rs_num  (inst[25:21]),
        .rt_num  (inst[20:16]),
        .rd_num  (rd_num),
        .rd_data (rd_data),
        .rd_we   (rd_we),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    wb_data_port u_wb_data_port (
        .clk       (clk),
        .rst       (rst),
        .mem_read  (ctrl.mem_read),
        .mem_write (ctrl.mem_write),
        .halted    (halted),
        .addr      (alu_result),   // base + offset
        .wdata     (rt_data),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .stall     (stall),
        .rdata     (load_data)
    );

endmodule

`default_nettype wire

//--- hdl/mips_core.sv
`timescale 1ns/10ps
`default_nettype none

module mips_core #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  halted,
    input  logic [31:0]           inst,
    output logic [31:0]           inst_addr,
    output mips_bus_pkg::wb_req_t wb_req,
    input  mips_bus_pkg::wb_rsp_t wb_rsp
);

    mips_isa_pkg::ctrl_t ctrl;

    control_unit u_control_unit (
        .opcode (mips_isa_pkg::opcode_t'(inst[31:26])),
        .funct  (mips_isa_pkg::funct_t'(inst[5:0])),
        .ctrl   (ctrl)
    );

    // full word goes to the data path for register numbers and immediates
    data_path #(
        .RESET_PC (RESET_PC)
    ) u_data_path (
        .clk       (clk),
        .rst       (rst),
        .halted    (halted),
        .inst      (inst),
        .ctrl      (ctrl),
        .inst_addr (inst_addr),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp)
    );

endmodule

`default_nettype wire

//--- verification/tb_mips_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mips_core;

    localparam logic [31:0] RESET_PC = 32'h0000_0000;
    localparam int TIMEOUT     = 50;  // cycles per wait
    localparam int HALT_CYCLES = 6;

    typedef enum logic [1:0] {BUS_XFER, PC_JUMP, HALT_HOLD} step_kind_t;

    typedef struct packed {
        step_kind_t            kind;
        mips_bus_pkg::wb_req_t req;      // expected transfer with the data seen on the bus
        logic [31:0]           from_pc;  // also the trigger address of a halt
        logic [31:0]           to_pc;
    } step_t;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  halted;
    logic [31:0]           inst;
    logic [31:0]           inst_addr;
    mips_bus_pkg::wb_req_t wb_req;
    mips_bus_pkg::wb_rsp_t wb_rsp;

    logic [31:0]           imem [0:63];
    logic [31:0]           dmem [0:63];
    mips_bus_pkg::wb_req_t done_q [$];  // completed transfers in order
    step_t                 steps [$];
    string                 names [$];
    int                    mismatches = 0;
    int                    failures = 0;

    always #4 clk = ~clk;

    assign inst = imem[inst_addr[7:2]];  // combinational instruction port

    mips_core #(
        .RESET_PC (RESET_PC)
    ) u_mips_core (
        .clk       (clk),
        .rst       (rst),
        .halted    (halted),
        .inst      (inst),
        .inst_addr (inst_addr),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp)
    );

    function automatic logic [31:0] r_format(mips_isa_pkg::funct_t f, int rs, int rt, int rd,
                                             int sh);
        return {mips_isa_pkg::OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'(sh), f};
    endfunction

    function automatic logic [31:0] i_format(mips_isa_pkg::opcode_t op, int rs, int rt, int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic logic [31:0] j_format(mips_isa_pkg::opcode_t op, int target);
        return {op, 26'(target >> 2)};
    endfunction

    // preload pattern of the data memory
    function automatic logic [31:0] fill_word(int idx);
        return 32'hcafe_0000 + 32'(idx) * 32'h0000_0111;
    endfunction

    task automatic place_inst(input logic [31:0] addr, input logic [31:0] word);
        imem[addr[7:2]] = word;
    endtask

    task automatic bus_event(input string name, input logic we, input logic [31:0] adr,
                             input logic [31:0] dat);
        step_t e;
        e = '0;
        e.kind    = BUS_XFER;
        e.req.cyc = 1'b1;
        e.req.stb = 1'b1;
        e.req.we  = we;
        e.req.adr = adr;
        e.req.dat = dat;
        e.req.sel = 4'hf;
        steps.push_back(e);
        names.push_back(name);
    endtask

    task automatic pc_event(input string name, input logic [31:0] from_pc,
                            input logic [31:0] to_pc);
        step_t e;
        e = '0;
        e.kind    = PC_JUMP;
        e.from_pc = from_pc;
        e.to_pc   = to_pc;
        steps.push_back(e);
        names.push_back(name);
    endtask

    task automatic halt_event(input string name, input logic [31:0] at_pc);
        step_t e;
        e = '0;
        e.kind    = HALT_HOLD;
        e.from_pc = at_pc;
        steps.push_back(e);
        names.push_back(name);
    endtask

    task automatic check_bus(input string name, input mips_bus_pkg::wb_req_t exp,
                             input mips_bus_pkg::wb_req_t act);
        if (act !== exp) begin
            $display("mismatch %s: expected we/adr/dat/sel %b/%h/%h/%h, actual %b/%h/%h/%h",
                     name, exp.we, exp.adr, exp.dat, exp.sel, act.we, act.adr, act.dat, act.sel);
            mismatches++;
        end
    endtask

    task automatic check_pc(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("mismatch %s: expected pc %h, actual pc %h", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic check_idle(input string name, input mips_bus_pkg::wb_req_t act);
        if (act.cyc !== 1'b0 || act.stb !== 1'b0) begin
            $display("mismatch %s: expected cyc=0 stb=0, actual cyc=%b stb=%b",
                     name, act.cyc, act.stb);
            mismatches++;
        end
    endtask

    task automatic wait_for_pc(input logic [31:0] addr, output logic found);
        int n;
        n = 0;
        while (inst_addr !== addr && n < TIMEOUT) begin
            @(posedge clk);
            #3;
            n++;
        end
        found = (inst_addr === addr);
    endtask

    task automatic write_program();
        for (int i = 0; i < 64; i++) begin
            imem[i[5:0]] = 32'd0;  // sll r0 acts as a nop
        end
        place_inst('h00, i_format(mips_isa_pkg::OP_ADDI, 0, 1, 'h0123));
        place_inst('h04, i_format(mips_isa_pkg::OP_ADDI, 0, 2, -2));
        place_inst('h08, r_format(mips_isa_pkg::F_ADD, 1, 2, 3, 0));
        place_inst('h0c, i_format(mips_isa_pkg::OP_SW, 0, 3, 'h40));
        place_inst('h10, r_format(mips_isa_pkg::F_SUB, 1, 2, 4, 0));
        place_inst('h14, i_format(mips_isa_pkg::OP_SW, 0, 4, 'h44));
        place_inst('h18, r_format(mips_isa_pkg::F_AND, 1, 2, 5, 0));
        place_inst('h1c, r_format(mips_isa_pkg::F_OR, 1, 2, 6, 0));
        place_inst('h20, i_format(mips_isa_pkg::OP_SW, 0, 5, 'h48));
        place_inst('h24, i_format(mips_isa_pkg::OP_SW, 0, 6, 'h4c));
        place_inst('h28, i_format(mips_isa_pkg::OP_ANDI, 2, 7, 'hff0f));
        place_inst('h2c, i_format(mips_isa_pkg::OP_ORI, 0, 8, 'h8001));
        place_inst('h30, i_format(mips_isa_pkg::OP_SW, 0, 7, 'h50));
        place_inst('h34, i_format(mips_isa_pkg::OP_SW, 0, 8, 'h54));
        place_inst('h38, i_format(mips_isa_pkg::OP_LUI, 0, 9, 'h1234));
        place_inst('h3c, i_format(mips_isa_pkg::OP_ORI, 9, 9, 'h5678));
        place_inst('h40, i_format(mips_isa_pkg::OP_SW, 0, 9, 'h58));
        place_inst('h44, r_format(mips_isa_pkg::F_SLT, 2, 1, 10, 0));
        place_inst('h48, r_format(mips_isa_pkg::F_SLTU, 2, 1, 11, 0));
        place_inst('h4c, i_format(mips_isa_pkg::OP_SLTI, 2, 12, -1));
        place_inst('h50, i_format(mips_isa_pkg::OP_SW, 0, 10, 'h5c));
        place_inst('h54, i_format(mips_isa_pkg::OP_SW, 0, 11, 'h60));
        place_inst('h58, i_format(mips_isa_pkg::OP_SW, 0, 12, 'h64));
        place_inst('h5c, r_format(mips_isa_pkg::F_SLL, 0, 1, 13, 4));
        place_inst('h60, r_format(mips_isa_pkg::F_SRL, 0, 2, 14, 28));
        place_inst('h64, i_format(mips_isa_pkg::OP_SW, 0, 13, 'h68));
        place_inst('h68, i_format(mips_isa_pkg::OP_SW, 0, 14, 'h6c));
        place_inst('h6c, i_format(mips_isa_pkg::OP_ADDI, 0, 0, 5));   // r0 must stay zero
        place_inst('h70, i_format(mips_isa_pkg::OP_SW, 0, 0, 'h70));
        place_inst('h74, i_format(mips_isa_pkg::OP_LW, 0, 15, 'h14));
        place_inst('h78, i_format(mips_isa_pkg::OP_SW, 0, 15, 'h74));
        place_inst('h7c, i_format(mips_isa_pkg::OP_LW, 0, 16, 'h18));
        place_inst('h80, i_format(mips_isa_pkg::OP_LW, 0, 17, 'h14));
        place_inst('h84, r_format(mips_isa_pkg::F_ADD, 16, 17, 18, 0));
        place_inst('h88, i_format(mips_isa_pkg::OP_SW, 0, 18, 'h78));
        place_inst('h8c, i_format(mips_isa_pkg::OP_BEQ, 1, 3, 2));
        place_inst('h90, i_format(mips_isa_pkg::OP_BNE, 1, 3, 2));
        place_inst('h94, i_format(mips_isa_pkg::OP_ADDI, 0, 19, 'hbad));  // skipped
        place_inst('h98, i_format(mips_isa_pkg::OP_SW, 0, 19, 'h7c));     // skipped
        place_inst('h9c, i_format(mips_isa_pkg::OP_BEQ, 1, 1, 1));
        place_inst('ha0, i_format(mips_isa_pkg::OP_SW, 0, 1, 'h7c));      // skipped
        place_inst('ha4, i_format(mips_isa_pkg::OP_BNE, 2, 2, 5));
        place_inst('ha8, j_format(mips_isa_pkg::OP_J, 'hb8));
        place_inst('hac, i_format(mips_isa_pkg::OP_ADDI, 0, 20, 'h77));
        place_inst('hb0, i_format(mips_isa_pkg::OP_SW, 0, 20, 'h7c));
        place_inst('hb4, j_format(mips_isa_pkg::OP_J, 'hc4));
        place_inst('hb8, i_format(mips_isa_pkg::OP_BEQ, 0, 0, -4));   // backward
        place_inst('hc4, j_format(mips_isa_pkg::OP_JAL, 'hf0));
        place_inst('hc8, i_format(mips_isa_pkg::OP_SW, 0, 31, 'h80));
        place_inst('hcc, i_format(mips_isa_pkg::OP_ADDI, 0, 22, 1));
        place_inst('hd0, i_format(mips_isa_pkg::OP_ADDI, 22, 22, 2));
        place_inst('hd4, i_format(mips_isa_pkg::OP_ADDI, 22, 22, 4));
        place_inst('hd8, i_format(mips_isa_pkg::OP_SW, 0, 22, 'h88));
        place_inst('hdc, j_format(mips_isa_pkg::OP_J, 'hdc));         // parks here
        // subroutine
        place_inst('hf0, i_format(mips_isa_pkg::OP_ADDI, 0, 21, 'h3c));
        place_inst('hf4, i_format(mips_isa_pkg::OP_SW, 0, 21, 'h84));
        place_inst('hf8, r_format(mips_isa_pkg::F_JR, 31, 0, 0, 0));
    endtask

    task automatic list_expected();
        pc_event("reset advance 0", 'h00, 'h04);
        pc_event("reset advance 1", 'h04, 'h08);
        bus_event("add", 1'b1, 'h40, 'h0000_0121);
        bus_event("sub", 1'b1, 'h44, 'h0000_0125);
        bus_event("and", 1'b1, 'h48, 'h0000_0122);
        bus_event("or", 1'b1, 'h4c, 'hffff_ffff);
        bus_event("andi zero extend", 1'b1, 'h50, 'h0000_ff0e);
        bus_event("ori zero extend", 1'b1, 'h54, 'h0000_8001);
        bus_event("lui ori", 1'b1, 'h58, 'h1234_5678);
        bus_event("slt", 1'b1, 'h5c, 'h0000_0001);
        bus_event("sltu", 1'b1, 'h60, 'h0000_0000);
        bus_event("slti", 1'b1, 'h64, 'h0000_0001);
        bus_event("sll", 1'b1, 'h68, 'h0000_1230);
        bus_event("srl", 1'b1, 'h6c, 'h0000_000f);
        bus_event("r0 stays zero", 1'b1, 'h70, 'h0000_0000);
        bus_event("lw word 5", 1'b0, 'h14, fill_word(5));
        bus_event("lw store back", 1'b1, 'h74, fill_word(5));
        bus_event("lw word 6", 1'b0, 'h18, fill_word(6));
        bus_event("lw back to back", 1'b0, 'h14, fill_word(5));
        bus_event("sum of loads", 1'b1, 'h78, fill_word(5) + fill_word(6));
        pc_event("beq not taken", 'h8c, 'h90);
        pc_event("bne taken", 'h90, 'h9c);
        pc_event("beq taken", 'h9c, 'ha4);
        pc_event("bne not taken", 'ha4, 'ha8);
        pc_event("j forward", 'ha8, 'hb8);
        pc_event("beq backward", 'hb8, 'hac);
        bus_event("after backward branch", 1'b1, 'h7c, 'h0000_0077);
        pc_event("j skip", 'hb4, 'hc4);
        pc_event("jal", 'hc4, 'hf0);
        bus_event("subroutine body", 1'b1, 'h84, 'h0000_003c);
        pc_event("jr return", 'hf8, 'hc8);
        bus_event("jal link", 1'b1, 'h80, 'h0000_00c8);
        halt_event("halted hold", 'hcc);
        halt_event("halted before store", 'hd4);
        bus_event("after halt", 1'b1, 'h88, 'h0000_0007);
        pc_event("park loop", 'hdc, 'hdc);
    endtask

    // wishbone slave with 0 to 3 wait cycles
    initial begin : wb_slave
        int                    wait_left;
        logic                  busy;
        logic [31:0]           pc_at_start;
        mips_bus_pkg::wb_req_t xfer;
        void'($urandom(254));
        wb_rsp      = '0;
        busy        = 1'b0;
        wait_left   = 0;
        pc_at_start = '0;
        xfer        = '0;
        for (int i = 0; i < 64; i++) begin
            dmem[i[5:0]] = fill_word(i);
        end
        forever begin
            @(posedge clk);
            #1;
            if (wb_rsp.ack) begin
                wb_rsp = '0;  // transfer completed at this edge
                busy   = 1'b0;
                done_q.push_back(xfer);
            end else if (wb_req.cyc && wb_req.stb) begin
                if (!busy) begin
                    busy        = 1'b1;
                    wait_left   = int'($urandom % 4);
                    pc_at_start = inst_addr;
                end else begin
                    check_pc("pc held during bus cycle", pc_at_start, inst_addr);
                end
                if (wait_left == 0) begin
                    xfer = wb_req;
                    if (wb_req.we) begin
                        dmem[wb_req.adr[7:2]] = wb_req.dat;
                    end else begin
                        xfer.dat = dmem[wb_req.adr[7:2]];
                    end
                    wb_rsp.dat = dmem[wb_req.adr[7:2]];
                    wb_rsp.ack = 1'b1;
                end else begin
                    wait_left--;
                end
            end
        end
    end

    initial begin : main
        step_t                 s;
        mips_bus_pkg::wb_req_t got;
        logic                  found;
        logic                  abort;
        logic [31:0]           held;
        int                    n;
        rst    = 1'b1;
        halted = 1'b0;
        abort  = 1'b0;
        write_program();
        list_expected();
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;
        #2;
        check_pc("reset vector", RESET_PC, inst_addr);
        check_idle("bus idle after reset", wb_req);

        for (int i = 0; i < steps.size() && !abort; i++) begin
            s = steps[i];
            case (s.kind)
                BUS_XFER: begin
                    n = 0;
                    while (done_q.size() == 0 && n < TIMEOUT) begin
                        @(posedge clk);
                        #3;
                        n++;
                    end
                    if (done_q.size() == 0) begin
                        $display("timeout: no bus transfer arrived for %s", names[i]);
                        failures++;
                        abort = 1'b1;
                    end else begin
                        got = done_q.pop_front();
                        check_bus(names[i], s.req, got);
                    end
                end
                PC_JUMP: begin
                    wait_for_pc(s.from_pc, found);
                    if (!found) begin
                        $display("timeout: pc never reached %h for %s", s.from_pc, names[i]);
                        failures++;
                        abort = 1'b1;
                    end else begin
                        @(posedge clk);
                        #3;
                        check_pc(names[i], s.to_pc, inst_addr);
                    end
                end
                default: begin
                    wait_for_pc(s.from_pc, found);
                    if (!found) begin
                        $display("timeout: pc never reached %h for %s", s.from_pc, names[i]);
                        failures++;
                        abort = 1'b1;
                    end else begin
                        @(posedge clk);
                        #1 halted = 1'b1;
                        #2 held = inst_addr;
                        repeat (HALT_CYCLES) begin
                            @(posedge clk);
                            #3;
                            check_pc(names[i], held, inst_addr);
                            check_idle(names[i], wb_req);
                        end
                        @(posedge clk);
                        #1 halted = 1'b0;
                        #2;
                    end
                end
            endcase
        end

        if (!abort && done_q.size() != 0) begin
            $display("unexpected bus transfer to %h after the last expected event",
                     done_q[0].adr);
            failures++;
        end
        $display("error count: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
hdl/mips_isa_pkg.sv
hdl/mips_bus_pkg.sv
hdl/alu.sv
hdl/regfile.sv
hdl/wb_data_port.sv
hdl/control_unit.sv
hdl/data_path.sv
hdl/mips_core.sv
verification/tb_mips_core.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --timescale 1ns/10ps --top-module tb_mips_core \
    -f tb.f -o tb_mips_core > build.log 2>&1 ||
    { cat build.log; exit 1; }

./obj_dir/tb_mips_core > sim.log 2>&1
cat sim.log

grep -q "Test failed" sim.log && exit 1
grep -q "Test completed successfully" sim.log || exit 1
exit 0
